// ==== src/feature_pkg.sv ====
package feature_pkg;

    localparam int PIXEL_W          = 8;
    localparam int IMG_W            = 8;
    localparam int IMG_H            = 8;
    localparam int PAIRS_PER_ROW    = IMG_W / 2;            // two pixels per input word
    localparam int FRAME_PAIRS      = PAIRS_PER_ROW * IMG_H;
    localparam int DETECT_THRESHOLD = 16;                   // keypoint margin

    // hi is the left (even) column, lo the right (odd) one
    typedef struct packed {
        logic [PIXEL_W-1:0] hi;
        logic [PIXEL_W-1:0] lo;
    } pixel_pair_t;

    typedef struct packed {
        logic        valid;
        logic        is_edge;   // right border step after pair 3
        logic        flush;     // synthetic zero row below the image
        logic [2:0]  row;
        logic [1:0]  pair;
        pixel_pair_t data;
    } step_t;

    // one pair index across three consecutive rows
    typedef struct packed {
        logic        valid;
        logic        is_edge;
        pixel_pair_t top;       // row r-2
        pixel_pair_t mid;       // row r-1
        pixel_pair_t bot;       // row r
    } column_t;

endpackage

// ==== src/pixel_loader.sv ====
`timescale 1ns/100ps

module pixel_loader (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  feature_pkg::pixel_pair_t in_data,
    output feature_pkg::step_t       step
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_FLUSH
    } state_t;

    state_t     state;
    logic [2:0] row;
    logic [1:0] pair;
    logic       edge_pend;     // edge step owed next cycle
    logic       last_pair;
    logic       last_row;

    assign last_pair = (pair == 2'(feature_pkg::PAIRS_PER_ROW - 1));
    assign last_row  = (row == 3'(feature_pkg::IMG_H - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            row       <= '0;
            pair      <= '0;
            edge_pend <= 1'b0;
            step      <= '0;
        end else begin
            step <= '0;    // no step unless issued below
            case (state)
                ST_IDLE: begin
                    if (in_valid) begin
                        step.valid <= 1'b1;
                        step.row   <= row;
                        step.pair  <= pair;
                        step.data  <= in_data;
                        pair       <= pair + 2'd1;
                        state      <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    if (edge_pend) begin
                        step.valid   <= 1'b1;
                        step.is_edge <= 1'b1;
                        step.row     <= row;
                        edge_pend    <= 1'b0;
                        row          <= row + 3'd1;    // wraps to 0 after row 7
                        if (last_row) begin
                            state <= ST_FLUSH;
                        end
                    end else if (in_valid) begin
                        step.valid <= 1'b1;
                        step.row   <= row;
                        step.pair  <= pair;
                        step.data  <= in_data;
                        pair       <= pair + 2'd1;
                        edge_pend  <= last_pair;
                    end
                end
                ST_FLUSH: begin
                    // zero row 8 pushes image row 7 out, in_valid ignored here
                    step.valid <= 1'b1;
                    step.flush <= 1'b1;
                    step.row   <= row;
                    if (edge_pend) begin
                        step.is_edge <= 1'b1;
                        edge_pend    <= 1'b0;
                        state        <= ST_IDLE;
                    end else begin
                        step.pair <= pair;
                        pair      <= pair + 2'd1;
                        edge_pend <= last_pair;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// ==== src/line_buffer.sv ====
`timescale 1ns/100ps

module line_buffer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  feature_pkg::step_t   step,
    output feature_pkg::column_t column
);

    // two row stores, selected by row parity
    feature_pkg::pixel_pair_t rows [2][feature_pkg::PAIRS_PER_ROW];

    logic cur_sel;
    logic first_row;
    logic second_row;

    // flush row 8 has row field 0, same parity as 8
    assign cur_sel    = step.row[0];
    assign first_row  = (step.row == 3'd0) && !step.flush;
    assign second_row = (step.row == 3'd1) && !step.flush;

    // slot of row r-2 is overwritten by row r
    always_ff @(posedge clk) begin
        if (step.valid && !step.is_edge) begin
            rows[cur_sel][step.pair] <= step.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            column <= '0;
        end else begin
            column.valid   <= step.valid && !first_row;    // row 0 only fills storage
            column.is_edge <= step.is_edge;
            if (step.is_edge) begin
                column.top <= '0;
                column.mid <= '0;
                column.bot <= '0;
            end else begin
                // zero border above row 0
                column.top <= second_row ? '0 : rows[cur_sel][step.pair];
                column.mid <= rows[~cur_sel][step.pair];
                column.bot <= step.data;
            end
        end
    end

endmodule

// ==== src/blur_detect.sv ====
`timescale 1ns/100ps

module blur_detect (
    input  logic                     clk,
    input  logic                     rst_n,
    input  feature_pkg::column_t     column,
    output logic                     out_valid,
    output feature_pkg::pixel_pair_t out_data,
    output logic [1:0]               out_kp,
    output logic                     frame_done
);

    localparam logic [4:0] LAST_PAIR = 5'(feature_pkg::FRAME_PAIRS - 1);

    // index 0 top, 1 mid, 2 bot
    feature_pkg::pixel_pair_t prev [3];     // column p-1
    logic [7:0]               prev2_lo [3]; // right pixel of column p-2
    logic [7:0]               right_hi [3]; // left pixel of column p
    logic [9:0]               h_left [3];
    logic [9:0]               h_right [3];
    logic [7:0]               blur_l;
    logic [7:0]               blur_r;
    logic                     kp_l;
    logic                     kp_r;
    logic                     have_prev;
    logic                     emit;
    logic [4:0]               out_cnt;

    function automatic logic [9:0] tap121(input logic [7:0] a, input logic [7:0] b,
                                          input logic [7:0] c);
        return {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
    endfunction

    function automatic logic [7:0] blur_px(input logic [9:0] t, input logic [9:0] m,
                                           input logic [9:0] b);
        logic [11:0] sum;
        sum = {2'b00, t} + {1'b0, m, 1'b0} + {2'b00, b};
        return sum[11:4];    // divide by 16, truncated
    endfunction

    function automatic logic is_kp(input logic [7:0] orig, input logic [7:0] blurred);
        return {1'b0, orig} > ({1'b0, blurred} + 9'(feature_pkg::DETECT_THRESHOLD));
    endfunction

    // edge column data is zero, so the right border comes for free
    assign right_hi[0] = column.top.hi;
    assign right_hi[1] = column.mid.hi;
    assign right_hi[2] = column.bot.hi;

    assign emit = column.valid && have_prev;    // nothing at pair 0

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            h_left[i]  = tap121(prev2_lo[i], prev[i].hi, prev[i].lo);
            h_right[i] = tap121(prev[i].hi, prev[i].lo, right_hi[i]);
        end
        blur_l = blur_px(h_left[0], h_left[1], h_left[2]);
        blur_r = blur_px(h_right[0], h_right[1], h_right[2]);
        kp_l   = is_kp(prev[1].hi, blur_l);
        kp_r   = is_kp(prev[1].lo, blur_r);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            have_prev  <= 1'b0;
            out_valid  <= 1'b0;
            out_data   <= '0;
            out_kp     <= 2'b00;
            frame_done <= 1'b0;
            out_cnt    <= '0;
            for (int i = 0; i < 3; i++) begin
                prev[i]     <= '0;
                prev2_lo[i] <= '0;
            end
        end else begin
            if (column.valid) begin
                if (column.is_edge) begin
                    // row start sees a zero left neighbour
                    have_prev <= 1'b0;
                    for (int i = 0; i < 3; i++) begin
                        prev[i]     <= '0;
                        prev2_lo[i] <= '0;
                    end
                end else begin
                    have_prev <= 1'b1;
                    for (int i = 0; i < 3; i++) begin
                        prev2_lo[i] <= prev[i].lo;
                    end
                    prev[0] <= column.top;
                    prev[1] <= column.mid;
                    prev[2] <= column.bot;
                end
            end
            out_valid   <= emit;
            out_data.hi <= blur_l;
            out_data.lo <= blur_r;
            out_kp      <= emit ? {kp_l, kp_r} : 2'b00;
            frame_done  <= emit && (out_cnt == LAST_PAIR);
            if (emit) begin
                out_cnt <= (out_cnt == LAST_PAIR) ? '0 : out_cnt + 5'd1;
            end
        end
    end

endmodule

// ==== src/feature_core.sv ====
`timescale 1ns/100ps

module feature_core (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  feature_pkg::pixel_pair_t in_data,
    output logic                     out_valid,
    output feature_pkg::pixel_pair_t out_data,
    output logic [1:0]               out_kp,
    output logic                     frame_done
);

    feature_pkg::step_t   step;      // loader to buffer
    feature_pkg::column_t column;    // buffer to blur

    pixel_loader i_pixel_loader (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .step     (step)
    );

    line_buffer i_line_buffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .step   (step),
        .column (column)
    );

    blur_detect i_blur_detect (
        .clk        (clk),
        .rst_n      (rst_n),
        .column     (column),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_kp     (out_kp),
        .frame_done (frame_done)
    );

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;    // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

// ==== test/feature_checker.sv ====
`timescale 1ns/100ps

module feature_checker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  feature_pkg::pixel_pair_t in_data,
    input  logic                     out_valid,
    input  feature_pkg::pixel_pair_t out_data,
    input  logic [1:0]               out_kp,
    input  logic                     frame_done,
    input  logic [19:0]              file_exp [32],
    output int                       value_errors,
    output int                       protocol_errors,
    output int                       frames_seen
);

    feature_pkg::pixel_pair_t frame_in [32];    // words of the current frame
    logic [5:0]               in_cnt;
    logic [5:0]               out_cnt;

    // zero outside the image
    function automatic int pixel_at(input int r, input int c);
        feature_pkg::pixel_pair_t pp;
        if (r < 0 || r >= feature_pkg::IMG_H || c < 0 || c >= feature_pkg::IMG_W) begin
            return 0;
        end
        pp = frame_in[5'(r * feature_pkg::PAIRS_PER_ROW + c / 2)];
        return (c % 2 == 0) ? int'(pp.hi) : int'(pp.lo);
    endfunction

    function automatic int blur_ref(input int r, input int c);
        int sum;
        int w;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                w = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);
                sum += w * pixel_at(r + dr, c + dc);
            end
        end
        return sum / 16;
    endfunction

    function automatic logic kp_ref(input int r, input int c);
        return (pixel_at(r, c) - blur_ref(r, c)) > feature_pkg::DETECT_THRESHOLD;
    endfunction

    always @(posedge clk) begin : compare
        int                       row;
        int                       pair;
        feature_pkg::pixel_pair_t exp_data;
        logic [1:0]               exp_kp;
        if (!rst_n) begin
            in_cnt          <= '0;
            out_cnt         <= '0;
            frames_seen     <= 0;
            value_errors    = 0;
            protocol_errors = 0;
        end else begin
            if (in_valid && in_cnt < 6'd32) begin
                frame_in[in_cnt[4:0]] <= in_data;
                in_cnt                <= in_cnt + 6'd1;
            end
            if (out_valid) begin
                if (in_cnt == 6'd0 || out_cnt >= 6'(feature_pkg::FRAME_PAIRS)) begin
                    $display("error %0t: output strobe outside a frame", $time);
                    protocol_errors++;
                end else begin
                    row         = int'(out_cnt[4:2]);
                    pair        = int'(out_cnt[1:0]);
                    exp_data.hi = 8'(blur_ref(row, 2 * pair));
                    exp_data.lo = 8'(blur_ref(row, 2 * pair + 1));
                    exp_kp      = {kp_ref(row, 2 * pair), kp_ref(row, 2 * pair + 1)};
                    if (out_data !== exp_data || out_kp !== exp_kp) begin
                        $display("error %0t: frame %0d row %0d pair %0d got %h/%b expected %h/%b",
                                 $time, frames_seen + 1, row, pair, out_data, out_kp,
                                 exp_data, exp_kp);
                        value_errors++;
                    end
                    if (frames_seen == 0 &&
                        {out_kp, out_data} !== file_exp[out_cnt[4:0]][17:0]) begin
                        $display("error %0t: frame 1 pair %0d got %h/%b, stim file has %h/%b",
                                 $time, out_cnt, out_data, out_kp,
                                 file_exp[out_cnt[4:0]][15:0], file_exp[out_cnt[4:0]][17:16]);
                        value_errors++;
                    end
                end
                out_cnt <= out_cnt + 6'd1;
            end
            if (frame_done !== (out_valid && out_cnt == 6'(feature_pkg::FRAME_PAIRS - 1))) begin
                $display("error %0t: frame_done %b at output %0d", $time, frame_done, out_cnt);
                protocol_errors++;
            end
            if (frame_done) begin
                frames_seen <= frames_seen + 1;
                in_cnt      <= '0;
                out_cnt     <= '0;
            end
        end
    end

endmodule

// ==== test/feature_core_properties.sv ====
`timescale 1ns/100ps

module feature_core_properties (
    input logic       clk,
    input logic       rst_n,
    input logic       in_valid,
    input logic       out_valid,
    input logic       frame_done
);

    logic [5:0] word_cnt;    // input words of the current frame
    logic       row_end;     // fourth word of rows 1 to 7

    assign row_end = in_valid && (word_cnt[1:0] == 2'd3) && (word_cnt[4:2] != 3'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_cnt <= '0;
        end else if (frame_done) begin
            word_cnt <= '0;
        end else if (in_valid) begin
            word_cnt <= word_cnt + 6'd1;
        end
    end

    // last pair of the row above leaves 4 cycles after the row's last word
    row_end_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(row_end, 4) |-> out_valid)
        else $error("last pair of a row missing 4 cycles after its fourth word");

    row_end_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        $past(row_end, 5) |-> !out_valid)
        else $error("strobe one cycle after the last pair of a row");

    // no strobe after reset or between frames
    strobe_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (word_cnt != 6'd0))
        else $error("output strobe before the first input word of a frame");

endmodule

// ==== test/tb_feature_core.sv ====
`timescale 1ns/100ps

module tb_feature_core;

    localparam int FRAMES        = 2;
    localparam int WORDS         = feature_pkg::FRAME_PAIRS;
    localparam int RESET_CYCLES  = 16;
    localparam int IDLE_START    = 8;     // quiet cycles before frame 1
    localparam int MAX_GAP       = 3;
    localparam int DRAIN         = 12;    // flush row and pipeline tail
    localparam int FRAME_CYCLES  = WORDS + feature_pkg::IMG_H * MAX_GAP + DRAIN;
    localparam int DRIVEN_CYCLES = RESET_CYCLES + IDLE_START + FRAMES * FRAME_CYCLES + DRAIN;
    localparam int CYCLE_LIMIT   = 2 * DRIVEN_CYCLES + 200;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    feature_pkg::pixel_pair_t in_data;
    logic                     out_valid;
    feature_pkg::pixel_pair_t out_data;
    logic [1:0]               out_kp;
    logic                     frame_done;

    logic [19:0] stim_mem [2 * WORDS];
    logic [15:0] in_words [WORDS];
    logic [19:0] exp_words [WORDS];    // {kp, blurred pair}
    int          value_errors;
    int          protocol_errors;
    int          frames_seen;
    int          cycles;
    integer      seed;

    clock_gen i_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    feature_core i_feature_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_kp     (out_kp),
        .frame_done (frame_done)
    );

    feature_checker i_feature_checker (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_data         (in_data),
        .out_valid       (out_valid),
        .out_data        (out_data),
        .out_kp          (out_kp),
        .frame_done      (frame_done),
        .file_exp        (exp_words),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .frames_seen     (frames_seen)
    );

    bind feature_core feature_core_properties i_feature_core_properties (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .out_valid  (out_valid),
        .frame_done (frame_done)
    );

    // frame 0 from the stim file, later frames random
    task automatic send_frame(input int frame);
        logic [31:0] rnd;
        int          gap;
        for (int w = 0; w < WORDS; w++) begin
            @(posedge clk);
            in_valid <= 1'b1;
            if (frame == 0) begin
                in_data <= in_words[5'(w)];
            end else begin
                rnd = $random(seed);
                in_data <= rnd[15:0];
            end
            if (w % feature_pkg::PAIRS_PER_ROW == feature_pkg::PAIRS_PER_ROW - 1) begin
                rnd = $random(seed);
                gap = 1 + (int'(rnd[7:0]) % MAX_GAP);    // edge slot plus slack
                repeat (gap) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                end
            end
        end
        while (frames_seen < frame + 1) @(posedge clk);
    endtask

    initial begin : run
        in_valid = 1'b0;
        in_data  = '0;
        seed     = 79115;
        $readmemh("test/feature_stim.txt", stim_mem);
        for (int i = 0; i < WORDS; i++) begin
            in_words[5'(i)]  = stim_mem[6'(2 * i)][15:0];
            exp_words[5'(i)] = stim_mem[6'(2 * i + 1)];
        end
        @(posedge rst_n);
        repeat (IDLE_START) @(posedge clk);
        for (int f = 0; f < FRAMES; f++) begin
            send_frame(f);
        end
        repeat (DRAIN) @(posedge clk);    // stray strobes after the last frame
        $display("errors: value %0d, protocol %0d; frames %0d of %0d",
                 value_errors, protocol_errors, frames_seen, FRAMES);
        if (value_errors == 0 && protocol_errors == 0 && frames_seen == FRAMES) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, only %0d of %0d frames finished",
                 cycles, frames_seen, FRAMES);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
src/feature_pkg.sv
src/pixel_loader.sv
src/line_buffer.sv
src/blur_detect.sv
src/feature_core.sv
test/clock_gen.sv
test/feature_checker.sv
test/feature_core_properties.sv
test/tb_feature_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the feature_core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_feature_core -Mdir obj_dir -f build.f

# the simulation status is not trusted, the log decides
./obj_dir/Vtb_feature_core | tee sim.log

if grep -qx "Result: PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// ==== test/feature_stim.txt ====
// frame 1 in raster order, two lines per input word: input pixel pair {even, odd}
// then expected {kp flags, blurred pair}; kp bit 1 is the even pixel
a020
23228
2020
01818
202b
1191a
2020
01912
2020
02828
2020
02020
2020
02021
2020
02018
2020
01820
2020
02d3a
2020
02d20
2020
02018
2020
01820
20f0
13a54
2020
03a20
2020
02018
2020
01920
2020
02d3a
2020
02d20
2020
02018
2a20
01a21
2020
02020
2020
02020
2020
02018
2020
01920
2020
02020
2020
02020
2020
02420
2020
01218
2020
01818
2020
01818
2064
12023
